// File: bench/core_tests.txt
# P <byte addr hex> <count> <words hex>   program words at consecutive addresses
# S <name> <addr hex> <value hex>   expected store in order; W <retire> <cycles>; T <retire>
# setup x1 = 100, x2 = -7, x3 = 3
P 000 3 06400093 ff900113 00300193
# r-type, each op followed by sw x10
P 00c 6 00208533 20a02023 40208533 20a02223 00309533 20a02423
P 024 6 00112533 20a02623 00113533 20a02823 0020c533 20a02a23
P 03c 8 00315533 20a02c23 40315533 20a02e23 0020e533 22a02023 0020f533 22a02223
# i-type, each op followed by sw x11
P 05c 8 fec10593 22b02423 ffa12593 22b02623 fff0b593 22b02823 fff0c593 22b02a23
P 07c 8 00f0e593 22b02c23 0f017593 22b02e23 00409593 24b02023 01c15593 24b02223
P 09c 2 40215593 24b02423
# sw x1, lw x12, sw x12, addi x0, sw x0, then an illegal word
P 0a4 6 24102623 24c02603 24c02823 00508013 24002a23 ffffffff
S r_add 200 0000005d
S r_sub 204 0000006b
S r_sll 208 00000320
S r_slt 20c 00000001
S r_sltu 210 00000000
S r_xor 214 ffffff9d
S r_srl 218 1fffffff
S r_sra 21c ffffffff
S r_or 220 fffffffd
S r_and 224 00000060
S i_addi 228 ffffffe5
S i_slti 22c 00000001
S i_sltiu 230 00000001
S i_xori 234 ffffff9b
S i_ori 238 0000006f
S i_andi 23c 000000f0
S i_slli 240 00000640
S i_srli 244 0000000f
S i_srai 248 fffffffe
S ls_store 24c 00000064
S ls_reload 250 00000064
S x0_store 254 00000000
# stall after 12 retired instructions, 20 cycles
W 12 20
# 46 legal instructions before the trap
T 46

// File: tb.f
+incdir+rtl
rtl/core_pkg.sv
rtl/instr_decoder.sv
rtl/core_control.sv
rtl/register_file.sv
rtl/alu.sv
rtl/execute_datapath.sv
rtl/mem_access.sv
rtl/rv32i_multicycle_core.sv
bench/clk_gen.sv
bench/tb_core.sv

// File: Bender.yml
package:
  name: rv32i_multicycle_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/core_pkg.sv
      - rtl/instr_decoder.sv
      - rtl/core_control.sv
      - rtl/register_file.sv
      - rtl/alu.sv
      - rtl/execute_datapath.sv
      - rtl/mem_access.sv
      - rtl/rv32i_multicycle_core.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - bench/clk_gen.sv
      - bench/tb_core.sv

// File: bench/tb_core.sv
`default_nettype none

`include "core_cfg.svh"

module tb_core;

  logic                      clk;
  logic                      rst_n;
  logic                      ena;
  logic [`CORE_XLEN-1:0]     mem_rd_data;
  logic [`CORE_XLEN-1:0]     mem_addr;
  logic [`CORE_XLEN-1:0]     mem_wr_data;
  logic                      mem_wr_ena;
  logic                      trap;
  logic [`CORE_XLEN-1:0]     pc;
  logic [`CORE_RETIRE_W-1:0] instructions_completed;

  // 256-word memory, word index from address bits 9:2
  logic [`CORE_XLEN-1:0] mem [256];

  // expectations from the test file
  string                 store_name[$];
  logic [`CORE_XLEN-1:0] store_addr[$];
  logic [`CORE_XLEN-1:0] store_data[$];
  int                    stall_at[$];
  int                    stall_len[$];
  int                    store_idx     = 0;
  int                    stall_idx     = 0;
  int                    n_words       = 0;
  int                    stall_total   = 0;
  int                    trap_count    = 0;
  bit                    trap_expected = 1'b0;
  bit                    tests_loaded  = 1'b0;
  time                   watchdog_limit;

  clk_gen u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rv32i_multicycle_core rv32i_multicycle_core_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .ena                    (ena),
    .mem_rd_data            (mem_rd_data),
    .mem_addr               (mem_addr),
    .mem_wr_data            (mem_wr_data),
    .mem_wr_ena             (mem_wr_ena),
    .trap                   (trap),
    .pc                     (pc),
    .instructions_completed (instructions_completed)
  );

  // combinational read port
  assign mem_rd_data = mem[mem_addr[9:2]];

  // ------------------------------
  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("[ERROR] %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // record tags: P program words, S expected store, W stall window, T trap
  task automatic load_tests();
    int                    fd;
    int                    ch;
    int                    code;
    int                    count;
    int                    len;
    int                    k;
    string                 tag;
    string                 name;
    logic [`CORE_XLEN-1:0] addr;
    logic [`CORE_XLEN-1:0] word;
    fd = $fopen("bench/core_tests.txt", "r");
    if (fd == 0) begin
      stop_with_failure("could not open bench/core_tests.txt");
    end
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag[0] == "#") begin
        // comment, skip to end of line
        ch = $fgetc(fd);
        while ((ch != 10) && (ch != -1)) begin
          ch = $fgetc(fd);
        end
      end else if (tag == "P") begin
        code = $fscanf(fd, "%h %d", addr, count);
        if (code != 2) begin
          stop_with_failure("malformed program record in the test file");
        end
        for (k = 0; k < count; k++) begin
          code = $fscanf(fd, "%h", word);
          if (code != 1) begin
            stop_with_failure("a program record in the test file is short of words");
          end
          mem[addr[9:2] + k] = word;
        end
        n_words += count;
      end else if (tag == "S") begin
        code = $fscanf(fd, "%s %h %h", name, addr, word);
        if (code != 3) begin
          stop_with_failure("malformed store record in the test file");
        end
        store_name.push_back(name);
        store_addr.push_back(addr);
        store_data.push_back(word);
      end else if (tag == "W") begin
        code = $fscanf(fd, "%d %d", count, len);
        if (code != 2) begin
          stop_with_failure("malformed stall record in the test file");
        end
        stall_at.push_back(count);
        stall_len.push_back(len);
        stall_total += len;
      end else if (tag == "T") begin
        code = $fscanf(fd, "%d", trap_count);
        if (code != 1) begin
          stop_with_failure("malformed trap record in the test file");
        end
        trap_expected = 1'b1;
      end else begin
        stop_with_failure({"unknown record in test file: ", tag});
      end
    end
    $fclose(fd);
    if (!trap_expected) begin
      stop_with_failure("the test file has no trap marker");
    end
    // worst case 5 cycles per word, plus stalls and slack
    watchdog_limit = (n_words * 5 + stall_total + 50) * 10;
  endtask

  task automatic check_idle_outputs(input string when);
    expect_equal({when, " mem_wr_ena"}, 0, mem_wr_ena);
    expect_equal({when, " trap"}, 0, trap);
    expect_equal({when, " retire count"}, 0, instructions_completed);
    expect_equal({when, " pc"}, 0, pc);
    expect_equal({when, " mem_addr"}, 0, mem_addr);
  endtask

  // ena low for a number of cycles, nothing may move
  task automatic hold_ena_low(input int cycles);
    logic [31:0] pc_before;
    logic [31:0] count_before;
    pc_before    = pc;
    count_before = instructions_completed;
    ena          = 1'b0;
    repeat (cycles) begin
      @(negedge clk);
      expect_equal("stall mem_wr_ena", 0, mem_wr_ena);
      expect_equal("stall retire count", count_before, instructions_completed);
      expect_equal("stall pc", pc_before, pc);
    end
    ena = 1'b1;
  endtask

  // ------------------------------
  // store monitor, in file order
  always @(posedge clk) begin
    if (mem_wr_ena === 1'b1) begin
      if (store_idx >= store_addr.size()) begin
        stop_with_failure("the core wrote memory after the last expected store");
      end else begin
        expect_equal({store_name[store_idx], " address"}, store_addr[store_idx], mem_addr);
        expect_equal(store_name[store_idx], store_data[store_idx], mem_wr_data);
        mem[mem_addr[9:2]] <= mem_wr_data;
        store_idx++;
      end
    end
  end

  // watchdog
  initial begin
    wait (tests_loaded);
    #(watchdog_limit);
    stop_with_failure("timeout, the core did not reach the trap in time");
  end

  initial begin
    ena = 1'b1;
    // background pattern, unique per word
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hbad0_0000 + i;
    end
    load_tests();
    tests_loaded = 1'b1;
    repeat (3) @(negedge clk);
    check_idle_outputs("reset held");
    @(posedge rst_n);
    check_idle_outputs("first cycle after reset");
    // run until the illegal word traps
    while (trap !== 1'b1) begin
      @(negedge clk);
      if ((stall_idx < stall_at.size()) && (instructions_completed == stall_at[stall_idx])) begin
        hold_ena_low(stall_len[stall_idx]);
        stall_idx++;
      end
    end
    expect_equal("trap retire count", trap_count, instructions_completed);
    // trap must stick, counter frozen
    repeat (10) begin
      @(negedge clk);
      expect_equal("trap held", 1, trap);
      expect_equal("trap retire count frozen", trap_count, instructions_completed);
    end
    if (store_idx == store_addr.size()) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      stop_with_failure("not every expected store was seen before the trap");
    end
  end

endmodule

`default_nettype wire

// File: bench/clk_gen.sv
`default_nettype none

module clk_gen (
  output logic clk,
  output logic rst_n
);

  // free running clock, period 10
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset low for ten rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: rtl/rv32i_multicycle_core.sv
`default_nettype none

`include "core_cfg.svh"

module rv32i_multicycle_core (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ena,
  input  logic [`CORE_XLEN-1:0]     mem_rd_data,
  output logic [`CORE_XLEN-1:0]     mem_addr,
  output logic [`CORE_XLEN-1:0]     mem_wr_data,
  output logic                      mem_wr_ena,
  output logic                      trap,
  output logic [`CORE_XLEN-1:0]     pc,
  output logic [`CORE_RETIRE_W-1:0] instructions_completed
);

  core_pkg::decoded_t    dec;
  core_pkg::core_ctrl_t  ctrl;
  logic [`CORE_XLEN-1:0] reg_b;
  logic [`CORE_XLEN-1:0] alu_last;
  logic [`CORE_XLEN-1:0] wb_data;

  // ------------------------------
  // input side
  instr_decoder u_decoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_rd_data (mem_rd_data),
    .ctrl        (ctrl),
    .dec         (dec)
  );

  core_control u_control (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .ena                    (ena),
    .dec                    (dec),
    .ctrl                   (ctrl),
    .trap                   (trap),
    .instructions_completed (instructions_completed)
  );

  // processing side
  execute_datapath u_datapath (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .dec      (dec),
    .wb_data  (wb_data),
    .reg_b    (reg_b),
    .alu_last (alu_last),
    .pc       (pc)
  );

  // output side
  mem_access u_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl        (ctrl),
    .pc          (pc),
    .alu_last    (alu_last),
    .reg_b       (reg_b),
    .mem_rd_data (mem_rd_data),
    .mem_addr    (mem_addr),
    .mem_wr_data (mem_wr_data),
    .wb_data     (wb_data),
    .mem_wr_ena  (mem_wr_ena)
  );

endmodule

`default_nettype wire

// File: rtl/mem_access.sv
`default_nettype none

`include "core_cfg.svh"

module mem_access (
  input  logic                  clk,
  input  logic                  rst_n,
  input  core_pkg::core_ctrl_t  ctrl,
  input  logic [`CORE_XLEN-1:0] pc,
  input  logic [`CORE_XLEN-1:0] alu_last,
  input  logic [`CORE_XLEN-1:0] reg_b,
  input  logic [`CORE_XLEN-1:0] mem_rd_data,
  output logic [`CORE_XLEN-1:0] mem_addr,
  output logic [`CORE_XLEN-1:0] mem_wr_data,
  output logic [`CORE_XLEN-1:0] wb_data,
  output logic                  mem_wr_ena
);

  logic [`CORE_XLEN-1:0] load_data;

  // fetch from pc, data access from computed address
  assign mem_addr    = ctrl.mem_addr_sel_result ? alu_last : pc;
  assign mem_wr_data = reg_b;
  assign mem_wr_ena  = ctrl.mem_wr_ena;

  // load data register
  always_ff @(posedge clk) begin
    if (ctrl.load_latch) begin
      load_data <= mem_rd_data;
    end
  end

  // write-back source
  assign wb_data = ctrl.wb_sel_load ? load_data : alu_last;

  // word access only
  a_store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    mem_wr_ena |-> (mem_addr[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: rtl/execute_datapath.sv
`default_nettype none

`include "core_cfg.svh"

module execute_datapath (
  input  logic                  clk,
  input  logic                  rst_n,
  input  core_pkg::core_ctrl_t  ctrl,
  input  core_pkg::decoded_t    dec,
  input  logic [`CORE_XLEN-1:0] wb_data,
  output logic [`CORE_XLEN-1:0] reg_b,
  output logic [`CORE_XLEN-1:0] alu_last,
  output logic [`CORE_XLEN-1:0] pc
);

  logic [`CORE_XLEN-1:0] rd_data0;
  logic [`CORE_XLEN-1:0] rd_data1;
  logic [`CORE_XLEN-1:0] reg_a;
  logic [`CORE_XLEN-1:0] src_a;
  logic [`CORE_XLEN-1:0] src_b;
  logic [`CORE_XLEN-1:0] alu_result;

  register_file u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_ena   (ctrl.reg_write),
    .wr_addr  (dec.rd),
    .rd_addr0 (dec.rs1),
    .rd_addr1 (dec.rs2),
    .wr_data  (wb_data),
    .rd_data0 (rd_data0),
    .rd_data1 (rd_data1)
  );

  // operand registers, reloaded every cycle
  always_ff @(posedge clk) begin
    reg_a <= rd_data0;
    reg_b <= rd_data1;
  end

  // ------------------------------
  // operand muxes
  assign src_a = ctrl.src_a_pc ? pc : reg_a;

  always_comb begin
    case (ctrl.src_b_sel)
      core_pkg::SRC_B_IMM:  src_b = dec.imm;
      core_pkg::SRC_B_FOUR: src_b = `CORE_XLEN'(4);
      default:              src_b = reg_b;
    endcase
  end

  alu u_alu (
    .a      (src_a),
    .b      (src_b),
    .op     (ctrl.alu_op),
    .result (alu_result)
  );

  // alu result held for write-back or address
  always_ff @(posedge clk) begin
    if (ctrl.alu_latch) begin
      alu_last <= alu_result;
    end
  end

  // pc, only the fetch increment writes it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `CORE_PC_START;
    end else if (ctrl.pc_write) begin
      pc <= alu_result;
    end
  end

endmodule

`default_nettype wire

// File: rtl/alu.sv
`default_nettype none

`include "core_cfg.svh"

module alu (
  input  logic [`CORE_XLEN-1:0] a,
  input  logic [`CORE_XLEN-1:0] b,
  input  core_pkg::alu_op_t     op,
  output logic [`CORE_XLEN-1:0] result
);

  logic [4:0] shamt;

  // only the low five bits shift
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      core_pkg::ALU_ADD:  result = a + b;
      core_pkg::ALU_SUB:  result = a - b;
      core_pkg::ALU_SLL:  result = a << shamt;
      // signed compare
      core_pkg::ALU_SLT:  result = {{(`CORE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      // unsigned compare
      core_pkg::ALU_SLTU: result = {{(`CORE_XLEN-1){1'b0}}, a < b};
      core_pkg::ALU_XOR:  result = a ^ b;
      core_pkg::ALU_SRL:  result = a >> shamt;
      // sign bit fills from the left
      core_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
      core_pkg::ALU_OR:   result = a | b;
      core_pkg::ALU_AND:  result = a & b;
      default:            result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
`default_nettype none

`include "core_cfg.svh"

module register_file (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_ena,
  input  logic [4:0]            wr_addr,
  input  logic [4:0]            rd_addr0,
  input  logic [4:0]            rd_addr1,
  input  logic [`CORE_XLEN-1:0] wr_data,
  output logic [`CORE_XLEN-1:0] rd_data0,
  output logic [`CORE_XLEN-1:0] rd_data1
);

  logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

  // sync write, x0 never written
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ena && (wr_addr != 5'd0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // async reads, x0 forced to zero
  assign rd_data0 = (rd_addr0 == 5'd0) ? '0 : regs[rd_addr0];
  assign rd_data1 = (rd_addr1 == 5'd0) ? '0 : regs[rd_addr1];

endmodule

`default_nettype wire

// File: rtl/core_control.sv
`default_nettype none

`include "core_cfg.svh"

module core_control (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ena,
  input  core_pkg::decoded_t        dec,
  output core_pkg::core_ctrl_t      ctrl,
  output logic                      trap,
  output logic [`CORE_RETIRE_W-1:0] instructions_completed
);

  core_pkg::core_state_t state;
  core_pkg::core_state_t next_state;
  core_pkg::core_ctrl_t  ctrl_raw;
  core_pkg::alu_op_t     exec_op;
  logic                  retire;

  // ------------------------------
  // state register and retire counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state                  <= core_pkg::FETCH;
      instructions_completed <= '0;
    end else if (ena) begin
      state <= next_state;
      if (retire) begin
        instructions_completed <= instructions_completed + 1'b1;
      end
    end
  end

  // last state of every instruction
  assign retire = (state == core_pkg::ALU_WB) || (state == core_pkg::MEM_WB) ||
                  (state == core_pkg::MEM_WRITE);
  assign trap = (state == core_pkg::TRAP);

  always_comb begin
    next_state = core_pkg::TRAP;
    case (state)
      core_pkg::FETCH: next_state = core_pkg::DECODE;
      core_pkg::DECODE: begin
        if (dec.illegal) begin
          next_state = core_pkg::TRAP;
        end else begin
          case (dec.op_class)
            core_pkg::CLS_RTYPE: next_state = core_pkg::EXEC_R;
            core_pkg::CLS_ITYPE: next_state = core_pkg::EXEC_I;
            default:             next_state = core_pkg::MEM_ADDR;
          endcase
        end
      end
      core_pkg::EXEC_R, core_pkg::EXEC_I: next_state = core_pkg::ALU_WB;
      core_pkg::MEM_ADDR: begin
        if (dec.op_class == core_pkg::CLS_STORE) begin
          next_state = core_pkg::MEM_WRITE;
        end else begin
          next_state = core_pkg::MEM_READ;
        end
      end
      core_pkg::MEM_READ: next_state = core_pkg::MEM_WB;
      core_pkg::ALU_WB, core_pkg::MEM_WB, core_pkg::MEM_WRITE: next_state = core_pkg::FETCH;
      // trap is sticky until reset
      default: next_state = core_pkg::TRAP;
    endcase
  end

  // ------------------------------
  // alu op for the execute states
  always_comb begin
    case (dec.funct3)
      // sub exists only in the register form
      3'b000:  exec_op = (dec.alt && dec.op_class == core_pkg::CLS_RTYPE) ?
                         core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      3'b001:  exec_op = core_pkg::ALU_SLL;
      3'b010:  exec_op = core_pkg::ALU_SLT;
      3'b011:  exec_op = core_pkg::ALU_SLTU;
      3'b100:  exec_op = core_pkg::ALU_XOR;
      3'b101:  exec_op = dec.alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      3'b110:  exec_op = core_pkg::ALU_OR;
      default: exec_op = core_pkg::ALU_AND;
    endcase
  end

  // state to control bundle
  always_comb begin
    ctrl_raw           = '0;
    ctrl_raw.alu_op    = core_pkg::ALU_ADD;
    ctrl_raw.src_b_sel = core_pkg::SRC_B_REG;
    case (state)
      core_pkg::FETCH: begin
        // ir <- mem[pc], pc <- pc + 4
        ctrl_raw.ir_write  = 1'b1;
        ctrl_raw.pc_write  = 1'b1;
        ctrl_raw.src_a_pc  = 1'b1;
        ctrl_raw.src_b_sel = core_pkg::SRC_B_FOUR;
      end
      core_pkg::EXEC_R: begin
        ctrl_raw.alu_op    = exec_op;
        ctrl_raw.alu_latch = 1'b1;
      end
      core_pkg::EXEC_I: begin
        ctrl_raw.alu_op    = exec_op;
        ctrl_raw.src_b_sel = core_pkg::SRC_B_IMM;
        ctrl_raw.alu_latch = 1'b1;
      end
      core_pkg::MEM_ADDR: begin
        // rs1 + imm, always add
        ctrl_raw.src_b_sel = core_pkg::SRC_B_IMM;
        ctrl_raw.alu_latch = 1'b1;
      end
      core_pkg::MEM_READ: begin
        ctrl_raw.mem_addr_sel_result = 1'b1;
        ctrl_raw.load_latch          = 1'b1;
      end
      core_pkg::MEM_WB: begin
        ctrl_raw.reg_write   = 1'b1;
        ctrl_raw.wb_sel_load = 1'b1;
      end
      core_pkg::MEM_WRITE: begin
        ctrl_raw.mem_addr_sel_result = 1'b1;
        ctrl_raw.mem_wr_ena          = 1'b1;
      end
      core_pkg::ALU_WB: ctrl_raw.reg_write = 1'b1;
      default: ;
    endcase
  end

  // stall kills every enable
  assign ctrl = ena ? ctrl_raw : '0;

  // memory write only in MEM_WRITE, and only for a decoded store
  a_store_state: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl.mem_wr_ena |-> (state == core_pkg::MEM_WRITE) &&
                        (dec.op_class == core_pkg::CLS_STORE));
  // a store never writes back to the register file
  a_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl.reg_write |-> (dec.op_class != core_pkg::CLS_STORE));

endmodule

`default_nettype wire

// File: rtl/instr_decoder.sv
`default_nettype none

`include "core_cfg.svh"

module instr_decoder (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`CORE_XLEN-1:0] mem_rd_data,
  input  core_pkg::core_ctrl_t  ctrl,
  output core_pkg::decoded_t    dec
);

  // addi x0, x0, 0
  localparam logic [`CORE_XLEN-1:0] NOP_WORD = 32'h0000_0013;

  logic [`CORE_XLEN-1:0] ir;
  logic [6:0]            opcode;
  logic [6:0]            funct7;
  logic [2:0]            funct3;
  logic                  funct7_ok;

  // instruction register, loaded in fetch
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ir <= NOP_WORD;
    end else if (ctrl.ir_write) begin
      ir <= mem_rd_data;
    end
  end

  assign opcode = ir[6:0];
  assign funct3 = ir[14:12];
  assign funct7 = ir[31:25];

  // only 0000000, or 0100000 for sub / sra / srai
  assign funct7_ok = (funct7 == 7'b0000000) ||
                     ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));

  always_comb begin
    dec.rd     = ir[11:7];
    dec.rs1    = ir[19:15];
    dec.rs2    = ir[24:20];
    dec.funct3 = funct3;
    dec.alt    = ir[30];
    dec.instr  = ir;
    dec.illegal  = 1'b0;
    dec.op_class = core_pkg::CLS_RTYPE;
    case (opcode)
      `CORE_OP_RTYPE: dec.illegal = !funct7_ok;
      `CORE_OP_ITYPE: begin
        dec.op_class = core_pkg::CLS_ITYPE;
        // funct7 only meaningful for the shifts
        dec.illegal  = ((funct3 == 3'b001) || (funct3 == 3'b101)) && !funct7_ok;
      end
      `CORE_OP_LOAD:  dec.op_class = core_pkg::CLS_LOAD;
      `CORE_OP_STORE: dec.op_class = core_pkg::CLS_STORE;
      default:        dec.illegal  = 1'b1;
    endcase
    // S format for stores, I format for everything else
    if (dec.op_class == core_pkg::CLS_STORE) begin
      dec.imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    end else begin
      dec.imm = {{20{ir[31]}}, ir[31:20]};
    end
  end

  // memory must never hand an undefined word to the decoder
  a_dec_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(dec));

endmodule

`default_nettype wire

// File: rtl/core_pkg.sv
`default_nettype none

`include "core_cfg.svh"

package core_pkg;

  // alu operations, funct3 order is not relied on
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_t;

  // main fsm states
  typedef enum logic [3:0] {
    FETCH, DECODE, EXEC_R, EXEC_I, MEM_ADDR,
    MEM_READ, MEM_WB, MEM_WRITE, ALU_WB, TRAP
  } core_state_t;

  // opcode classes kept by this core
  typedef enum logic [1:0] {CLS_RTYPE, CLS_ITYPE, CLS_LOAD, CLS_STORE} op_class_t;

  // alu b operand sources
  typedef enum logic [1:0] {SRC_B_REG, SRC_B_IMM, SRC_B_FOUR} src_b_sel_t;

  // ------------------------------
  // decoded view of the instruction register
  typedef struct packed {
    op_class_t             op_class;
    logic                  illegal;
    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [2:0]            funct3;
    // funct7 bit 5, sub / sra select
    logic                  alt;
    logic [`CORE_XLEN-1:0] imm;
    logic [`CORE_XLEN-1:0] instr;
  } decoded_t;

  // per-cycle control bundle from the fsm
  typedef struct packed {
    logic       ir_write;
    logic       pc_write;
    logic       src_a_pc;
    src_b_sel_t src_b_sel;
    alu_op_t    alu_op;
    logic       alu_latch;
    logic       mem_addr_sel_result;
    logic       mem_wr_ena;
    logic       load_latch;
    logic       reg_write;
    logic       wb_sel_load;
  } core_ctrl_t;

endpackage

`default_nettype wire

// File: rtl/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// datapath and address width
`define CORE_XLEN 32
// architectural register count
`define CORE_NREGS 32
// first fetch address after reset
`define CORE_PC_START 32'h0000_0000

// ------------------------------
// supported major opcodes
`define CORE_OP_RTYPE 7'b0110011
`define CORE_OP_ITYPE 7'b0010011
`define CORE_OP_LOAD 7'b0000011
`define CORE_OP_STORE 7'b0100011

// retired instruction counter width
`define CORE_RETIRE_W 32

`endif
